// File: dv/pool_vectors.txt
# Record: kind (w plain, b start on previous pulse, x ignored inputs, z size zero), pool size,
# then size*size beats as {lane2,lane1,lane0} hex, then the expected {lane2,lane1,lane0} maxima.
# Positive values, sizes 3 and 2.
w 3
380045003c00 34003c004000 3c0046003800
3e0040004200 400038003e00 480042003400
42003e004400 380044003c00 450034004000
480046004400
w 2
564034004900 400038004500
56403c004800 42003e003c00
56403e004900
# Negatives only, zeros only, and mixed signs.
w 2
b4008000c000 00000000b800
bc008000bc00 80000000c400
00008000b800
b 2
3c00c4000000 bc0040008000
3c00bc000000 b80038008000
3c0040000000
z 0
x 3
4200c0003800 4400c4003c00 4000bc003400
4500c2004000 4200c0003e00 4400c4003800
4000c8003c00 3c00c0003400 4200c2003800
4500bc004000
# One beat, then a full 7 x 7 window.
w 1
c4007bff0001
c4007bff0001
w 7
6000c0003c00 4200bc004000 3c00c4004800 5000b8003800 4000c0003c00 4200bc004000 3c00c4004800
5000b8003800 4000c0003c00 4200bc004000 3c00c4004800 5000b8003800 4000c0003c00 4200bc004000
3c00c4004800 5000b8003800 4000c0003c00 4200bc004000 3c00c4004800 5000b8003800 4000c0003c00
4200bc004000 3c00c4004800 5000b8003800 4000c0003c00 4200bc004000 3c00c4004800 5000b8003800
4000c0003c00 4200bc004000 3c00c4005000 5000b8003800 4000c0003c00 4200bc004000 3c00c4004800
5000b8003800 4000c0003c00 4200bc004000 3c00c4004800 5000b8003800 4000c0003c00 4200bc004000
3c00c4004800 5000b8003800 4000c0003c00 4200bc004000 3c00c4004800 5000b8003800 4000b0003c00
6000b0005000
b 1
800100003c00
800100003c00

// File: verilog.f
source/pool_pkg.sv
source/fp16_max_cmp.sv
source/max_pool_lane.sv
source/pool_window_ctrl.sv
source/max_pool_array.sv
dv/max_pool_chk.sv
dv/max_pool_tb.sv

// File: Makefile
# Verilator build and run for the max-pooling unit.

VERILATOR ?= verilator
TOP       ?= max_pool_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/max_pool_tb.sv
`timescale 1ns/1ps
`default_nettype none

module max_pool_tb;

	localparam string VECTOR_FILE = "dv/pool_vectors.txt";
	localparam int unsigned SEED = 32'h886a_295b;
	localparam pool_pkg::lanes_t JUNK = {3{16'h7bff}}; // Largest finite half in every lane.

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	pool_pkg::pool_size_t pool_size;
	logic                 in_valid;
	pool_pkg::lanes_t     in_data;
	logic                 out_valid;
	pool_pkg::lanes_t     out_data;
	logic                 busy;

	// Records as read from the vector file.
	byte              kind_q [$];
	int               size_q [$];
	pool_pkg::lanes_t beat_q [$];
	pool_pkg::lanes_t result_q [$];

	// Expected results in the order the windows closed.
	pool_pkg::lanes_t pending_q [$];
	string            pending_name_q [$];

	int errors = 0;
	int pulses = 0;
	int windows = 0;
	int cycles = 0;
	int cycle_limit = 0;
	bit vectors_ok = 1'b0;
	int beat_base;
	pool_pkg::lanes_t held_out = '0;

	max_pool_array DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.pool_size (pool_size),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Cycle limit is set once the records are known.
	initial begin
		while ((cycle_limit == 0) || (cycles < cycle_limit)) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic check_value(input string name, input pool_pkg::lanes_t expected,
		input pool_pkg::lanes_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Results are taken mid-cycle.
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				pulses++;
				if (pending_q.size() == 0) begin
					$display("Unexpected out_valid pulse in cycle %0d, no window was open.", cycles);
					errors++;
				end else begin
					held_out = pending_q.pop_front();
					check_value(pending_name_q.pop_front(), held_out, out_data);
				end
			end else begin
				check_value("out_data hold between pulses", held_out, out_data);
			end
		end
	end

	task automatic advance;
		@(posedge clk);
		#1;
	endtask

	task automatic idle_inputs;
		start = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
	endtask

	task automatic wait_for_results;
		while (pending_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic read_vectors;
		int fd;
		int code;
		int size;
		byte kind;
		bit done;
		logic [8 * 200 - 1:0] line;
		pool_pkg::lanes_t value;
		fd = $fopen(VECTOR_FILE, "r");
		vectors_ok = (fd != 0);
		done = (fd == 0);
		while (!done) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				code = $fgets(line, fd); // Rest of a comment line.
			end else begin
				code = $fscanf(fd, "%d", size);
				kind_q.push_back(kind);
				size_q.push_back(size);
				for (int n = 0; n < size * size; n++) begin
					code = $fscanf(fd, "%h", value);
					beat_q.push_back(value);
				end
				value = '0;
				if (size != 0) begin
					code = $fscanf(fd, "%h", value);
				end
				result_q.push_back(value);
				if (code != 1) begin
					vectors_ok = 1'b0;
					done = 1'b1;
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (kind_q.size() == 0) begin
			vectors_ok = 1'b0;
		end
	endtask

	// Record kinds are w plain, b start on the previous pulse, x with ignored inputs and z zero size.
	task automatic run_record(input int idx, input int base);
		byte kind;
		int size;
		int beats;
		int gap;
		string name;
		kind = kind_q[idx];
		size = size_q[idx];
		beats = size * size;
		name = $sformatf("record %0d (%c, size %0d)", idx, kind, size);
		if (kind != "b") begin
			advance();
			idle_inputs();
			wait_for_results();
			repeat ($urandom % 4) begin
				advance();
			end
		end
		if (kind == "x") begin
			repeat (2) begin
				advance();
				in_valid = 1'b1; // Idle beats with no window open.
				in_data = JUNK;
			end
		end
		advance();
		start = 1'b1;
		pool_size = pool_pkg::pool_size_t'(size);
		in_valid = (kind == "x"); // A beat in the start cycle is dropped.
		in_data = JUNK;
		if (kind == "z") begin
			advance();
			check_value({name, " busy"}, '0, pool_pkg::lanes_t'(busy));
			start = 1'b0;
			in_valid = 1'b1;
			advance();
			idle_inputs();
		end else begin
			windows++;
			for (int n = 0; n < beats; n++) begin
				gap = $urandom % 4;
				if ((kind == "x") && (n == 1) && (gap == 0)) begin
					gap = 1;
				end
				for (int g = 0; g < gap; g++) begin
					advance();
					idle_inputs();
					if ((kind == "x") && (n == 1) && (g == 0)) begin
						start = 1'b1; // Start while busy.
						pool_size = 3'd1;
					end
				end
				advance();
				start = 1'b0;
				in_valid = 1'b1;
				in_data = beat_q[base + n];
				if (n == beats - 1) begin
					pending_q.push_back(result_q[idx]);
					pending_name_q.push_back(name);
				end
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		pool_size = '0;
		in_valid = 1'b0;
		in_data = '0;
		void'($urandom(SEED));
		read_vectors();
		if (!vectors_ok) begin
			$display("Could not read the records in %s.", VECTOR_FILE);
			$display("FAIL: see errors above");
			$finish;
		end else begin
			cycle_limit = kind_q.size() * (49 * 4 + 10) + 100;
			repeat (16) begin
				@(posedge clk);
			end
			#1;
			rst_n = 1'b1;
			beat_base = 0;
			for (int i = 0; i < kind_q.size(); i++) begin
				run_record(i, beat_base);
				beat_base += size_q[i] * size_q[i];
			end
			advance();
			idle_inputs();
			wait_for_results();
			repeat (4) begin
				advance();
			end
			check_value("out_valid pulse count", pool_pkg::lanes_t'(windows),
				pool_pkg::lanes_t'(pulses));
			$display("Done with %0d windows, %0d pulses, %0d errors.", windows, pulses, errors);
			if (errors == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: dv/max_pool_chk.sv
`timescale 1ns/1ps
`default_nettype none

module max_pool_chk (
	input wire logic             clk,
	input wire logic             rst_n,
	input wire logic             start,
	input wire logic             busy,
	input wire logic             out_valid,
	input wire pool_pkg::lanes_t out_data
);

	// Result pulse is a single cycle, even back to back.
	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid stayed high for two cycles");

	a_reset_idle: assert property (@(posedge clk)
		!rst_n |=> !busy)
		else $error("busy high right after reset");

	// Busy only rises on a start.
	a_busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && !start) |=> !busy)
		else $error("busy rose without a start");

	a_pulse_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $fell(busy))
		else $error("out_valid does not follow the fall of busy");

	a_result_held: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> $stable(out_data))
		else $error("out_data changed between result pulses");

endmodule

bind max_pool_array max_pool_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.start     (start),
	.busy      (busy),
	.out_valid (out_valid),
	.out_data  (out_data)
);

`default_nettype wire

// File: source/max_pool_array.sv
`timescale 1ns/1ps
`default_nettype none

module max_pool_array (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire pool_pkg::pool_size_t pool_size,
	input  wire logic                 in_valid,
	input  wire pool_pkg::lanes_t     in_data,
	output logic                      out_valid,
	output pool_pkg::lanes_t          out_data,
	output logic                      busy
);

	// Controls shared by every lane.
	logic load;
	logic accum;
	logic last;

	// Per-lane views of the packed buses.
	pool_pkg::fp16_t lane_in [pool_pkg::PARA_POOL_Y];
	pool_pkg::fp16_t lane_result [pool_pkg::PARA_POOL_Y];

	pool_window_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.pool_size (pool_size),
		.in_valid  (in_valid),
		.load      (load),
		.accum     (accum),
		.last      (last),
		.out_valid (out_valid),
		.busy      (busy)
	);

	for (genvar i = 0; i < pool_pkg::PARA_POOL_Y; i++) begin : g_lane
		// Lane i owns bits [16*i +: 16].
		assign lane_in[i] = in_data[i * pool_pkg::DATA_WIDTH +: pool_pkg::DATA_WIDTH];

		max_pool_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.in_value (lane_in[i]),
			.load     (load),
			.accum    (accum),
			.last     (last),
			.result   (lane_result[i])
		);
	end

	// Pack the lane results back, lane 0 low.
	always_comb begin
		for (int j = 0; j < pool_pkg::PARA_POOL_Y; j++) begin
			out_data[j * pool_pkg::DATA_WIDTH +: pool_pkg::DATA_WIDTH] = lane_result[j];
		end
	end

endmodule

`default_nettype wire

// File: source/pool_window_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pool_window_ctrl (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire pool_pkg::pool_size_t pool_size,
	input  wire logic                 in_valid,
	output logic                      load,
	output logic                      accum,
	output logic                      last,
	output logic                      out_valid,
	output logic                      busy
);

	pool_pkg::window_state_t state;
	pool_pkg::window_state_t state_next;

	pool_pkg::beat_count_t target; // Beats in the current window.
	pool_pkg::beat_count_t count; // Beats taken so far.
	pool_pkg::beat_count_t window_beats;

	logic start_ok;
	logic beat;
	logic final_beat;

	// DONE behaves as idle, so a start may land on the result pulse.
	assign start_ok = start && (state != pool_pkg::ACCUM) && (pool_size != '0);

	// Beats only count once the window is open.
	assign beat = in_valid && (state == pool_pkg::ACCUM);

	assign window_beats = pool_pkg::beat_count_t'(pool_size)
		* pool_pkg::beat_count_t'(pool_size);

	assign final_beat = (count == target - pool_pkg::beat_count_t'(1));

	// Lane controls.
	assign load = beat && (count == '0);
	assign accum = beat && (count != '0);
	assign last = beat && final_beat;

	assign out_valid = (state == pool_pkg::DONE);
	assign busy = (state == pool_pkg::ACCUM);

	always_comb begin
		state_next = state;
		case (state)
			pool_pkg::IDLE: begin
				if (start_ok) begin
					state_next = pool_pkg::ACCUM;
				end
			end
			pool_pkg::ACCUM: begin
				if (last) begin
					state_next = pool_pkg::DONE;
				end
			end
			pool_pkg::DONE: begin
				// One cycle only, unless the next window opens right away.
				state_next = start_ok ? pool_pkg::ACCUM : pool_pkg::IDLE;
			end
			default: begin
				state_next = pool_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pool_pkg::IDLE;
			target <= '0;
			count <= '0;
		end else begin
			state <= state_next;
			if (start_ok) begin
				target <= window_beats; // Latched once per window.
				count <= '0;
			end else if (beat) begin
				if (final_beat) begin
					count <= '0;
				end else begin
					count <= count + pool_pkg::beat_count_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/max_pool_lane.sv
`timescale 1ns/1ps
`default_nettype none

module max_pool_lane (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire pool_pkg::fp16_t in_value,
	input  wire logic            load,
	input  wire logic            accum,
	input  wire logic            last,
	output pool_pkg::fp16_t      result
);

	// Running maximum of the window in progress.
	pool_pkg::fp16_t running;

	// Comparator output and the value the window would end on.
	pool_pkg::fp16_t cmp_max;
	pool_pkg::fp16_t next_max;

	fp16_max_cmp u_cmp (
		.held      (running),
		.incoming  (in_value),
		.max_value (cmp_max)
	);

	// First beat of a window starts fresh from the input.
	assign next_max = load ? in_value : cmp_max;

	always_ff @(posedge clk) begin
		if (load || accum) begin
			running <= next_max;
		end
	end

	// Result stays put while the next window accumulates.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (last) begin
			result <= next_max; // Covers the one-beat window too.
		end
	end

endmodule

`default_nettype wire

// File: source/fp16_max_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_max_cmp (
	input  wire pool_pkg::fp16_t held,
	input  wire pool_pkg::fp16_t incoming,
	output pool_pkg::fp16_t      max_value
);

	// Sign bit and magnitude of each operand.
	logic                                held_sign;
	logic                                in_sign;
	logic [pool_pkg::DATA_WIDTH - 2:0]   held_mag;
	logic [pool_pkg::DATA_WIDTH - 2:0]   in_mag;
	logic                                take_incoming;

	assign held_sign = held[pool_pkg::DATA_WIDTH - 1];
	assign in_sign = incoming[pool_pkg::DATA_WIDTH - 1];
	assign held_mag = held[pool_pkg::DATA_WIDTH - 2:0];
	assign in_mag = incoming[pool_pkg::DATA_WIDTH - 2:0];

	// Incoming value replaces the held one only when strictly larger.
	always_comb begin
		if ((held_mag == '0) && (in_mag == '0)) begin
			take_incoming = 1'b0; // +0 and -0 compare equal.
		end else if (held_sign != in_sign) begin
			take_incoming = !in_sign; // Positive side wins.
		end else if (!held_sign) begin
			take_incoming = (in_mag > held_mag);
		end else begin
			// Both negative, smaller magnitude is the larger number.
			take_incoming = (in_mag < held_mag);
		end
	end

	assign max_value = take_incoming ? incoming : held;

endmodule

`default_nettype wire

// File: source/pool_pkg.sv
`default_nettype none

package pool_pkg;

	// Activation format is IEEE half precision.
	localparam int DATA_WIDTH = 16;

	// Lanes pooled side by side, one value per lane per beat.
	localparam int PARA_POOL_Y = 3;

	localparam int POOL_SIZE_WIDTH = 3; // Window side, 1 to 7.
	localparam int COUNT_WIDTH = 6; // Up to 7 x 7 = 49 beats.

	// One float16 value.
	typedef logic [DATA_WIDTH - 1:0] fp16_t;

	// All lanes packed together, lane 0 in the low bits.
	typedef logic [PARA_POOL_Y * DATA_WIDTH - 1:0] lanes_t;

	// Side length of the pooling window.
	typedef logic [POOL_SIZE_WIDTH - 1:0] pool_size_t;

	// Beat count within one window.
	typedef logic [COUNT_WIDTH - 1:0] beat_count_t;

	// Window controller states.
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for a start.
		ACCUM = 2'd1, // Counting input beats.
		DONE = 2'd2 // Result pulse cycle.
	} window_state_t;

endpackage

`default_nettype wire
